// ==== include/phold_settings.svh ====
`ifndef PHOLD_SETTINGS_SVH
`define PHOLD_SETTINGS_SVH

// event message fields
`define PHOLD_NB_LPID 3
`define PHOLD_TIME_WID 16
`define PHOLD_MSG_WID 32

// history storage, 16 entries per LP
`define PHOLD_HIST_WID 32
`define PHOLD_NB_HIST_DEPTH 4
`define PHOLD_NB_HIST_ADDR (`PHOLD_NB_LPID + `PHOLD_NB_HIST_DEPTH)
`define PHOLD_OFFSET_WID 8

// random word, split in three equal slices
`define PHOLD_NB_RND 24

// smallest time step between an event and the one it spawns
`define PHOLD_MIN_GAP 10

`endif

// ==== source/phold_pkg.sv ====
`include "phold_settings.svh"

package phold_pkg;

   typedef enum logic {
      REGULAR_EVT = 1'b0,
      CANCEL_EVT  = 1'b1
   } evt_type_e;

   // message as seen on the event network
   typedef struct packed {
      logic [`PHOLD_MSG_WID-`PHOLD_TIME_WID-`PHOLD_NB_LPID-2:0] pad;
      evt_type_e                  kind;
      logic [`PHOLD_NB_LPID-1:0]  target;
      logic [`PHOLD_TIME_WID-1:0] ts;
   } event_msg_t;

   // one processed event as kept in history memory
   // offset is the distance to the event it spawned
   typedef struct packed {
      logic [`PHOLD_HIST_WID-`PHOLD_NB_LPID-`PHOLD_OFFSET_WID-`PHOLD_TIME_WID-2:0] pad;
      logic [`PHOLD_NB_LPID-1:0]    target;
      logic [`PHOLD_OFFSET_WID-1:0] offset;
      evt_type_e                    kind;
      logic [`PHOLD_TIME_WID-1:0]   ts;
   } hist_entry_t;

   typedef struct packed {
      logic [`PHOLD_NB_RND/3-1:0] delay_rnd;
      logic [`PHOLD_NB_RND/3-1:0] target_rnd;
      logic [`PHOLD_NB_RND/3-1:0] gap_rnd;
   } rnd_fields_t;

   typedef enum logic [2:0] {
      IDLE,
      STALL,
      READ_HIST,
      PROC_DELAY,
      GEN_EVT,
      WRITE_HIST,
      SEND_EVT,
      WAIT
   } core_state_e;

   typedef enum logic [1:0] {
      HIST_IDLE,
      HIST_REQ,
      HIST_WAIT
   } hist_state_e;

   typedef struct packed {
      event_msg_t                 msg;
      logic [`PHOLD_TIME_WID-1:0] gvt;
      rnd_fields_t                rnd;
   } cur_event_t;

endpackage

// ==== source/fwft_fifo.sv ====
module fwft_fifo #(
   parameter int WIDTH = 32,
   parameter int DEPTH = 16
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     clear,
   input  logic                     wr_en,
   input  logic [WIDTH-1:0]         din,
   input  logic                     rd_en,
   output logic [WIDTH-1:0]         dout,
   output logic                     empty,
   output logic [$clog2(DEPTH):0]   count
);

   localparam int AW = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic             do_rd;

   // a read on an empty FIFO is ignored
   assign do_rd = rd_en && !empty;
   assign empty = (count == '0);
   // head word is always visible
   assign dout  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + {{AW{1'b0}}, wr_en} - {{AW{1'b0}}, do_rd};
      end
   end

endmodule

// ==== source/event_intake.sv ====
`include "phold_settings.svh"

module event_intake
   import phold_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       event_valid,
   input  event_msg_t                 cur_event_msg,
   input  logic [`PHOLD_TIME_WID-1:0] global_time,
   input  logic [`PHOLD_NB_RND-1:0]   random_in,
   input  logic                       in_delay,
   output cur_event_t                 cur_evt,
   output event_msg_t                 new_evt,
   output logic                       start,
   output logic                       delay_done
);

   rnd_fields_t rnd;
   logic [3:0]  delay_cnt;

   assign rnd = cur_evt.rnd;

   // event, GVT and random word are held for the whole processing run
   always_ff @(posedge clk) begin
      if (event_valid) begin
         cur_evt.msg <= cur_event_msg;
         cur_evt.gvt <= global_time;
         cur_evt.rnd <= random_in;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         start     <= 1'b0;
         delay_cnt <= '0;
      end else begin
         start <= event_valid;
         if (!in_delay) begin
            delay_cnt <= '0;
         end else if (!delay_done) begin
            delay_cnt <= delay_cnt + 1'b1;
         end
      end
   end

   // up to 15 idle cycles of emulated event processing
   assign delay_done = (delay_cnt >= rnd.delay_rnd[3:0]);

   // spawned event, at least MIN_GAP ahead of the current one
   always_comb begin
      new_evt        = '0;
      new_evt.kind   = REGULAR_EVT;
      new_evt.target = rnd.target_rnd[`PHOLD_NB_LPID-1:0];
      new_evt.ts     = cur_evt.msg.ts + `PHOLD_TIME_WID'(`PHOLD_MIN_GAP)
                       + `PHOLD_TIME_WID'(rnd.gap_rnd[5:0]);
   end

endmodule

// ==== source/history_engine.sv ====
`include "phold_settings.svh"

module history_engine
   import phold_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst_n,
   input  cur_event_t                      cur_evt,
   input  event_msg_t                      new_evt,
   input  logic                            phase_read,
   input  logic                            phase_write,
   input  logic                            gen_next,
   input  logic                            clear,
   input  logic                            rbk_pop,
   input  logic [`PHOLD_HIST_WID-1:0]      hist_data_rd,
   input  logic                            hist_access_grant,
   input  logic [`PHOLD_NB_HIST_DEPTH-1:0] hist_size,
   output logic                            hist_rq,
   output logic                            hist_wr_en,
   output logic [`PHOLD_NB_HIST_ADDR-1:0]  hist_addr,
   output logic [`PHOLD_HIST_WID-1:0]      hist_data_wr,
   output logic                            hist_done,
   output logic                            discard_cur,
   output logic                            gen_cancel,
   output event_msg_t                      cancel_msg,
   output logic                            rbk_empty,
   output hist_entry_t                     rbk_entry
);

   localparam int CNT_WID = `PHOLD_NB_HIST_DEPTH + 1;

   hist_state_e                     state;
   hist_state_e                     state_nxt;
   logic [`PHOLD_NB_HIST_DEPTH-1:0] xfer_cnt;
   logic [CNT_WID-1:0]              xfer_total;
   logic [CNT_WID-1:0]              phase_total;
   logic [CNT_WID-1:0]              keep_count;
   logic                            phase_any;
   logic                            granted;
   logic                            last_xfer;
   logic                            launch;
   logic                            done_q;
   logic                            rd_vld;
   hist_entry_t                     rd_q;
   hist_entry_t                     gen_entry;
   logic [`PHOLD_TIME_WID-1:0]      gen_offset;
   logic                            expired;
   logic                            match;
   logic                            rollback;

   assign phase_any   = phase_read | phase_write;
   // read count comes from memory, write count is whatever survived the filter
   assign phase_total = phase_read ? CNT_WID'(hist_size) : keep_count;
   assign granted     = (state != HIST_IDLE) && hist_access_grant;
   assign last_xfer   = ({1'b0, xfer_cnt} == xfer_total - 1'b1);
   assign launch      = (state == HIST_IDLE) && phase_any && !done_q && (phase_total != '0);

   always_comb begin
      state_nxt = state;
      case (state)
         HIST_IDLE: begin
            if (launch) begin
               state_nxt = HIST_REQ;
            end
         end
         HIST_REQ, HIST_WAIT: begin
            if (!granted) begin
               state_nxt = HIST_WAIT;
            end else if (last_xfer) begin
               state_nxt = HIST_IDLE;
            end else begin
               state_nxt = HIST_REQ;
            end
         end
         default: state_nxt = HIST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= HIST_IDLE;
         xfer_cnt <= '0;
         done_q   <= 1'b0;
         rd_vld   <= 1'b0;
      end else begin
         state  <= state_nxt;
         done_q <= granted && last_xfer;
         rd_vld <= granted && phase_read;
         if (launch) begin
            xfer_cnt <= '0;
         end else if (granted) begin
            xfer_cnt <= xfer_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (launch) begin
         xfer_total <= phase_total;
      end
      if (granted && phase_read) begin
         rd_q <= hist_entry_t'(hist_data_rd);
      end
   end

   assign hist_rq    = (state != HIST_IDLE);
   assign hist_wr_en = hist_rq && phase_write;
   assign hist_addr  = {cur_evt.msg.target, xfer_cnt};
   // an empty phase finishes in its first cycle
   assign hist_done  = done_q || ((state == HIST_IDLE) && phase_any && !done_q
                                  && (phase_total == '0));

   // filter, in priority order: expired, annihilated pair, straggler rollback
   assign expired  = (rd_q.ts < cur_evt.gvt);
   assign match    = !expired && !discard_cur && (rd_q.kind != cur_evt.msg.kind)
                     && (rd_q.ts == cur_evt.msg.ts);
   assign rollback = !expired && !match && (cur_evt.msg.kind == REGULAR_EVT)
                     && (rd_q.kind == REGULAR_EVT) && (rd_q.ts > cur_evt.msg.ts);

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         discard_cur <= 1'b0;
         gen_cancel  <= 1'b0;
      end else if (rd_vld && match) begin
         discard_cur <= 1'b1;
         gen_cancel  <= (cur_evt.msg.kind == CANCEL_EVT);
      end
   end

   // the annihilated entry already spawned an event, which must be recalled
   always_ff @(posedge clk) begin
      if (rd_vld && match && (cur_evt.msg.kind == CANCEL_EVT)) begin
         cancel_msg <= '{pad: '0, kind: CANCEL_EVT, target: rd_q.target,
                         ts: rd_q.ts + rd_q.offset};
      end
   end

   assign gen_offset = new_evt.ts - cur_evt.msg.ts;

   always_comb begin
      gen_entry        = '0;
      gen_entry.target = new_evt.target;
      gen_entry.offset = gen_offset[`PHOLD_OFFSET_WID-1:0];
      gen_entry.kind   = cur_evt.msg.kind;
      gen_entry.ts     = cur_evt.msg.ts;
   end

   fwft_fifo #(
      .WIDTH (`PHOLD_HIST_WID),
      .DEPTH (2 ** `PHOLD_NB_HIST_DEPTH)
   ) keep_buffer (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (clear),
      .wr_en ((rd_vld && !expired && !match && !rollback) || gen_next),
      .din   (gen_next ? gen_entry : rd_q),
      .rd_en (granted && phase_write),
      .dout  (hist_data_wr),
      .empty (),
      .count (keep_count)
   );

   fwft_fifo #(
      .WIDTH (`PHOLD_HIST_WID),
      .DEPTH (2 ** `PHOLD_NB_HIST_DEPTH)
   ) rollback_buffer (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (clear),
      .wr_en (rd_vld && rollback),
      .din   (rd_q),
      .rd_en (rbk_pop),
      .dout  (rbk_entry),
      .empty (rbk_empty),
      .count ()
   );

endmodule

// ==== source/event_sender.sv ====
module event_sender
   import phold_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        start,
   input  logic        stall,
   input  logic        ack,
   input  logic        delay_done,
   input  logic        hist_done,
   input  logic        discard_cur,
   input  logic        gen_cancel,
   input  event_msg_t  cancel_msg,
   input  event_msg_t  new_evt,
   input  cur_event_t  cur_evt,
   input  logic        rbk_empty,
   input  hist_entry_t rbk_entry,
   output logic        phase_read,
   output logic        phase_write,
   output logic        gen_next,
   output logic        in_delay,
   output logic        clear,
   output logic        rbk_pop,
   output logic        new_event_ready,
   output event_msg_t  out_event_msg,
   output logic        ready,
   output logic        active
);

   core_state_e state;
   core_state_e state_nxt;
   logic        rbk_second;
   logic        rbk_step;
   event_msg_t  null_msg;
   event_msg_t  primary_msg;
   event_msg_t  rbk_cancel_msg;
   event_msg_t  rbk_regular_msg;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:       if (start) state_nxt = STALL;
         STALL:      if (!stall) state_nxt = READ_HIST;
         READ_HIST:  if (hist_done) state_nxt = PROC_DELAY;
         PROC_DELAY: if (delay_done) state_nxt = GEN_EVT;
         GEN_EVT:    state_nxt = WRITE_HIST;
         WRITE_HIST: if (hist_done) state_nxt = SEND_EVT;
         SEND_EVT:   state_nxt = WAIT;
         WAIT:       if (ack && rbk_empty) state_nxt = IDLE;
         default:    state_nxt = IDLE;
      endcase
   end

   assign phase_read  = (state == READ_HIST);
   assign phase_write = (state == WRITE_HIST);
   assign in_delay    = (state == PROC_DELAY);
   // an annihilated event leaves nothing behind in history
   assign gen_next    = (state == GEN_EVT) && !discard_cur;
   assign rbk_step    = (state == WAIT) && ack && !rbk_empty;
   assign rbk_pop     = rbk_step && rbk_second;
   assign clear       = (state == WAIT) && ack && rbk_empty;
   assign ready       = (state == IDLE) && !start;
   assign active      = !ready;

   assign null_msg        = '{pad: '0, kind: CANCEL_EVT, target: '0, ts: '0};
   assign rbk_cancel_msg  = '{pad: '0, kind: CANCEL_EVT, target: rbk_entry.target,
                              ts: rbk_entry.ts + rbk_entry.offset};
   // straggler re-executes the rolled-back event on this LP
   assign rbk_regular_msg = '{pad: '0, kind: REGULAR_EVT, target: cur_evt.msg.target,
                              ts: rbk_entry.ts};

   always_comb begin
      if (discard_cur) begin
         primary_msg = gen_cancel ? cancel_msg : null_msg;
      end else if (cur_evt.msg.kind == CANCEL_EVT) begin
         primary_msg = null_msg;
      end else begin
         primary_msg = new_evt;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state           <= IDLE;
         new_event_ready <= 1'b0;
         rbk_second      <= 1'b0;
      end else begin
         state <= state_nxt;
         if (state == SEND_EVT) begin
            new_event_ready <= 1'b1;
         end else if (clear) begin
            new_event_ready <= 1'b0;
         end
         // cancel first, then the regular half of each pair
         if (rbk_step) begin
            rbk_second <= !rbk_second;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == SEND_EVT) begin
         out_event_msg <= primary_msg;
      end else if (rbk_step) begin
         out_event_msg <= rbk_second ? rbk_regular_msg : rbk_cancel_msg;
      end
   end

endmodule

// ==== source/phold_core.sv ====
`include "phold_settings.svh"

module phold_core
   import phold_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            event_valid,
   input  event_msg_t                      cur_event_msg,
   input  logic [`PHOLD_TIME_WID-1:0]      global_time,
   input  logic [`PHOLD_NB_RND-1:0]        random_in,
   input  logic                            stall,
   input  logic                            ack,
   input  logic [`PHOLD_HIST_WID-1:0]      hist_data_rd,
   input  logic                            hist_access_grant,
   input  logic [`PHOLD_NB_HIST_DEPTH-1:0] hist_size,
   output logic                            new_event_ready,
   output event_msg_t                      out_event_msg,
   output logic                            ready,
   output logic                            active,
   output logic                            hist_rq,
   output logic                            hist_wr_en,
   output logic [`PHOLD_NB_HIST_ADDR-1:0]  hist_addr,
   output logic [`PHOLD_HIST_WID-1:0]      hist_data_wr
);

   cur_event_t  cur_evt;
   event_msg_t  new_evt;
   event_msg_t  cancel_msg;
   hist_entry_t rbk_entry;
   logic        start;
   logic        delay_done;
   logic        in_delay;
   logic        phase_read;
   logic        phase_write;
   logic        gen_next;
   logic        clear;
   logic        rbk_pop;
   logic        rbk_empty;
   logic        hist_done;
   logic        discard_cur;
   logic        gen_cancel;

   event_intake u_event_intake (
      .clk           (clk),
      .rst_n         (rst_n),
      .event_valid   (event_valid),
      .cur_event_msg (cur_event_msg),
      .global_time   (global_time),
      .random_in     (random_in),
      .in_delay      (in_delay),
      .cur_evt       (cur_evt),
      .new_evt       (new_evt),
      .start         (start),
      .delay_done    (delay_done)
   );

   history_engine u_history_engine (
      .clk               (clk),
      .rst_n             (rst_n),
      .cur_evt           (cur_evt),
      .new_evt           (new_evt),
      .phase_read        (phase_read),
      .phase_write       (phase_write),
      .gen_next          (gen_next),
      .clear             (clear),
      .rbk_pop           (rbk_pop),
      .hist_data_rd      (hist_data_rd),
      .hist_access_grant (hist_access_grant),
      .hist_size         (hist_size),
      .hist_rq           (hist_rq),
      .hist_wr_en        (hist_wr_en),
      .hist_addr         (hist_addr),
      .hist_data_wr      (hist_data_wr),
      .hist_done         (hist_done),
      .discard_cur       (discard_cur),
      .gen_cancel        (gen_cancel),
      .cancel_msg        (cancel_msg),
      .rbk_empty         (rbk_empty),
      .rbk_entry         (rbk_entry)
   );

   event_sender u_event_sender (
      .clk             (clk),
      .rst_n           (rst_n),
      .start           (start),
      .stall           (stall),
      .ack             (ack),
      .delay_done      (delay_done),
      .hist_done       (hist_done),
      .discard_cur     (discard_cur),
      .gen_cancel      (gen_cancel),
      .cancel_msg      (cancel_msg),
      .new_evt         (new_evt),
      .cur_evt         (cur_evt),
      .rbk_empty       (rbk_empty),
      .rbk_entry       (rbk_entry),
      .phase_read      (phase_read),
      .phase_write     (phase_write),
      .gen_next        (gen_next),
      .in_delay        (in_delay),
      .clear           (clear),
      .rbk_pop         (rbk_pop),
      .new_event_ready (new_event_ready),
      .out_event_msg   (out_event_msg),
      .ready           (ready),
      .active          (active)
   );

endmodule

// ==== testbench/phold_checker.sv ====
`include "phold_settings.svh"

module phold_checker
   import phold_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       event_valid,
   input  event_msg_t                 cur_event_msg,
   input  logic [`PHOLD_TIME_WID-1:0] global_time,
   input  logic [`PHOLD_NB_RND-1:0]   random_in,
   input  logic                       stall,
   input  logic                       ack,
   input  logic                       new_event_ready,
   input  event_msg_t                 out_event_msg,
   input  logic                       hist_rq,
   input  logic                       ready,
   input  logic                       active,
   output int                         err_count,
   output int                         events_done,
   output int                         events_bad
);
   timeunit 1ns;
   timeprecision 1ns;

   // per-LP history as the core should hold it
   hist_entry_t hist_ref [8][$];
   event_msg_t  exp_q [$];
   int          msg_idx;
   int          evt_errs;
   int          evt_lp;
   logic        prev_nr;
   logic        prev_ack;
   event_msg_t  prev_msg;

   function automatic event_msg_t make_msg(evt_type_e kind, logic [2:0] tgt,
                                           logic [15:0] ts);
      event_msg_t m;
      m        = '0;
      m.kind   = kind;
      m.target = tgt;
      m.ts     = ts;
      return m;
   endfunction

   // filter history, append the spawned entry, queue the expected messages
   function automatic void build_expected(event_msg_t ev, logic [15:0] gvt,
                                          logic [23:0] rnd);
      hist_entry_t old [$];
      hist_entry_t keep [$];
      hist_entry_t rbk [$];
      hist_entry_t ne;
      logic        discard;
      event_msg_t  cmsg;
      logic [15:0] nts;
      int          lp;
      discard = 1'b0;
      cmsg    = make_msg(CANCEL_EVT, 3'd0, 16'd0);
      lp      = int'(ev.target);
      old     = hist_ref[lp];
      foreach (old[i]) begin
         if (old[i].ts < gvt) begin
            continue;
         end else if (!discard && old[i].kind != ev.kind && old[i].ts == ev.ts) begin
            discard = 1'b1;
            if (ev.kind == CANCEL_EVT) begin
               cmsg = make_msg(CANCEL_EVT, old[i].target, old[i].ts + 16'(old[i].offset));
            end
         end else if (ev.kind == REGULAR_EVT && old[i].kind == REGULAR_EVT
                      && old[i].ts > ev.ts) begin
            rbk.push_back(old[i]);
         end else begin
            keep.push_back(old[i]);
         end
      end
      nts = ev.ts + 16'(`PHOLD_MIN_GAP) + 16'(rnd[5:0]);
      if (!discard) begin
         ne        = '0;
         ne.target = rnd[10:8];
         ne.offset = 8'(nts - ev.ts);
         ne.kind   = ev.kind;
         ne.ts     = ev.ts;
         keep.push_back(ne);
      end
      hist_ref[lp] = keep;
      if (discard || ev.kind == CANCEL_EVT) begin
         exp_q.push_back(cmsg);
      end else begin
         exp_q.push_back(make_msg(REGULAR_EVT, rnd[10:8], nts));
      end
      foreach (rbk[i]) begin
         exp_q.push_back(make_msg(CANCEL_EVT, rbk[i].target, rbk[i].ts + 16'(rbk[i].offset)));
         exp_q.push_back(make_msg(REGULAR_EVT, ev.target, rbk[i].ts));
      end
   endfunction

   always @(posedge clk) begin
      if (!rst_n) begin
         err_count   <= 0;
         events_done <= 0;
         events_bad  <= 0;
         msg_idx     = 0;
         evt_errs    = 0;
         prev_nr     <= 1'b0;
         prev_ack    <= 1'b0;
      end else begin
         // core reports busy from intake until the last message is taken
         if (ready == active || (ready && exp_q.size() != 0)) begin
            $display("FAIL t=%0t: ready %0b active %0b with %0d messages owed",
                     $time, ready, active, exp_q.size());
            err_count <= err_count + 1;
            evt_errs++;
         end
         if (event_valid) begin
            build_expected(cur_event_msg, global_time, random_in);
            evt_lp = int'(cur_event_msg.target);
         end
         if (stall && hist_rq) begin
            $display("FAIL t=%0t: history request seen while stall is high", $time);
            err_count <= err_count + 1;
            evt_errs++;
         end
         // message must hold while waiting for ack
         if (prev_nr && !prev_ack && new_event_ready && out_event_msg != prev_msg) begin
            $display("FAIL t=%0t: output message changed without ack", $time);
            err_count <= err_count + 1;
            evt_errs++;
         end
         if (ack && new_event_ready) begin
            if (exp_q.size() == 0) begin
               $display("FAIL t=%0t: core sent a message that no event accounts for",
                        $time);
               err_count <= err_count + 1;
            end else begin
               if (out_event_msg != exp_q[0]) begin
                  $display("FAIL t=%0t: event %0d message %0d got %h expected %h",
                           $time, events_done, msg_idx, out_event_msg, exp_q[0]);
                  err_count <= err_count + 1;
                  evt_errs++;
               end
               void'(exp_q.pop_front());
               msg_idx++;
               if (exp_q.size() == 0) begin
                  $display("event %0d lp %0d: %0d messages, %0d errors",
                           events_done, evt_lp, msg_idx, evt_errs);
                  events_done <= events_done + 1;
                  if (evt_errs != 0) begin
                     events_bad <= events_bad + 1;
                  end
                  msg_idx  = 0;
                  evt_errs = 0;
               end
            end
         end
         prev_nr  <= new_event_ready;
         prev_ack <= ack;
         prev_msg <= out_event_msg;
      end
   end

endmodule

// ==== testbench/tb_phold_core.sv ====
`include "phold_settings.svh"

module tb_phold_core
   import phold_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ns;

   localparam int N_EVENTS = 150;

   logic                            clk = 1'b0;
   logic                            rst_n;
   logic                            event_valid;
   event_msg_t                      cur_event_msg;
   logic [`PHOLD_TIME_WID-1:0]      global_time;
   logic [`PHOLD_NB_RND-1:0]        random_in;
   logic                            stall;
   logic                            ack;
   logic [`PHOLD_HIST_WID-1:0]      hist_data_rd = '0;
   logic                            hist_access_grant = 1'b0;
   logic [`PHOLD_NB_HIST_DEPTH-1:0] hist_size = '0;
   logic                            new_event_ready;
   event_msg_t                      out_event_msg;
   logic                            ready;
   logic                            active;
   logic                            hist_rq;
   logic                            hist_wr_en;
   logic [`PHOLD_NB_HIST_ADDR-1:0]  hist_addr;
   logic [`PHOLD_HIST_WID-1:0]      hist_data_wr;
   int                              err_count;
   int                              events_done;
   int                              events_bad;
   int                              tb_errs;
   logic [31:0]                     lcg_state = 32'h37cb_2422;

   // history memory model
   logic [31:0] hist_mem [128];
   logic [4:0]  lp_count [8];
   logic        waiting;
   int          wait_left;

   always #10 clk = ~clk;

   phold_core u_phold_core (.*);

   phold_checker u_checker (.*);

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_below(int n);
      logic [31:0] r;
      r = lcg_next();
      return int'(r[31:16]) % n;
   endfunction

   always @(posedge clk) begin
      if (!rst_n) begin
         hist_access_grant <= 1'b0;
         hist_data_rd      <= '0;
         hist_size         <= '0;
         waiting           <= 1'b0;
         for (int i = 0; i < 8; i++) begin
            lp_count[i] <= '0;
         end
      end else begin
         hist_size <= lp_count[hist_addr[6:4]][3:0];
         if (hist_access_grant) begin
            hist_access_grant <= 1'b0;
            waiting           <= 1'b0;
            if (hist_wr_en) begin
               hist_mem[hist_addr]       <= hist_data_wr;
               lp_count[hist_addr[6:4]] <= {1'b0, hist_addr[3:0]} + 5'd1;
            end else if ({1'b0, hist_addr[3:0]} + 5'd1 == lp_count[hist_addr[6:4]]) begin
               // whole LP read, count is rebuilt by the write phase
               lp_count[hist_addr[6:4]] <= '0;
            end
         end else if (hist_rq) begin
            if (!waiting) begin
               wait_left = rand_below(4);
               waiting <= 1'b1;
            end else begin
               wait_left--;
            end
            if (wait_left <= 0) begin
               hist_access_grant <= 1'b1;
               hist_data_rd      <= hist_mem[hist_addr];
            end
         end
      end
   end

   task automatic run_event(int idx, ref event_msg_t reg_q [$]);
      event_msg_t  m;
      logic [31:0] r;
      int          stall_left;
      int          hold;
      int          pick;
      logic        seen;
      m        = '0;
      m.kind   = REGULAR_EVT;
      m.target = 3'(rand_below(8));
      m.ts     = 16'(idx * 3 + rand_below(48));
      if (idx % 3 == 2 && reg_q.size() > 0) begin
         // recall a recently sent regular event
         pick = reg_q.size() - 1 - rand_below(reg_q.size() < 4 ? reg_q.size() : 4);
         m    = reg_q[pick];
         m.kind = CANCEL_EVT;
      end else if (idx % 7 == 6) begin
         m.kind = CANCEL_EVT;
      end else if (idx % 11 == 10 && reg_q.size() > 0) begin
         // same regular event twice, so a later cancel can meet two matches
         m = reg_q[reg_q.size() - 1];
         reg_q.push_back(m);
      end else begin
         reg_q.push_back(m);
      end
      r          = lcg_next();
      stall_left = (idx % 5 == 0) ? 5 + rand_below(4) : 0;
      hold       = (idx % 7 == 0) ? 12 : rand_below(3);
      seen       = 1'b0;
      do @(posedge clk); while (!ready);
      event_valid   <= 1'b1;
      cur_event_msg <= m;
      global_time   <= 16'(idx * 3);
      random_in     <= r[23:0];
      stall         <= (stall_left > 0);
      @(posedge clk);
      event_valid <= 1'b0;
      forever begin
         @(posedge clk);
         if (stall_left > 0) begin
            stall_left--;
            if (stall_left == 0) begin
               stall <= 1'b0;
            end
         end
         if (ack) begin
            ack <= 1'b0;
         end else if (new_event_ready) begin
            seen = 1'b1;
            if (hold > 0) begin
               hold--;
            end else begin
               ack  <= 1'b1;
               hold = rand_below(3);
            end
         end else if (seen) begin
            break;
         end
      end
   endtask

   initial begin
      event_msg_t reg_q [$];
      rst_n         = 1'b0;
      event_valid   = 1'b0;
      cur_event_msg = '0;
      global_time   = '0;
      random_in     = '0;
      stall         = 1'b0;
      ack           = 1'b0;
      tb_errs       = 0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      @(posedge clk);
      if (!ready || new_event_ready || hist_rq) begin
         $display("FAIL t=%0t: core is not idle after reset", $time);
         tb_errs++;
      end
      for (int i = 0; i < N_EVENTS; i++) begin
         run_event(i, reg_q);
      end
      repeat (4) @(posedge clk);
      $display("events %0d done, %0d bad, %0d errors", events_done, events_bad,
               err_count + tb_errs);
      if (err_count == 0 && tb_errs == 0 && events_done == N_EVENTS) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial begin
      #(N_EVENTS * 400 * 20);
      $display("watchdog expired before all events were processed");
      $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== phold_core.f ====
+incdir+include
source/phold_pkg.sv
source/fwft_fifo.sv
source/event_intake.sv
source/history_engine.sv
source/event_sender.sv
source/phold_core.sv
testbench/phold_checker.sv
testbench/tb_phold_core.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary -j 0 --timing -Wno-fatal
TOP       := tb_phold_core
FLIST     := phold_core.f
OBJ_DIR   := obj_dir
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove build products"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
